//--- Bender.yml
package:
  name: zhxpu

sources:
  - zhxpu_pkg.sv
  - pc_fetch.sv
  - decoder.sv
  - register_file.sv
  - alu.sv
  - ram_controller.sv
  - zhxpu.sv
  - target: test
    files:
      - zhxpu_props.sv
      - zhxpu_tb.sv

//--- alu.sv
`default_nettype none

module alu import zhxpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire hold,
	input wire id_exe_t id_exe,
	output mem_req_t data_req,
	input wire data_done,
	input wire word_t rdata,
	output wb_t exe_dest,
	output wb_t wb
);
	word_t result;
	word_t load_word;
	word_t load_buf;
	logic mem_finished;

	always_comb begin
		case (id_exe.alu_op)
			ALU_ADD: result = id_exe.op1 + id_exe.op2;
			ALU_SUB: result = id_exe.op1 - id_exe.op2;
			ALU_AND: result = id_exe.op1 & id_exe.op2;
			ALU_OR: result = id_exe.op1 | id_exe.op2;
			ALU_SLL: result = id_exe.op1 << id_exe.op2[3:0];
			ALU_PASS: result = id_exe.op2;
			default: result = '0;
		endcase
	end

	// Request drops once served, so a stalled SW is not written twice
	assign data_req = '{
		en: id_exe.valid && (id_exe.mem_read || id_exe.mem_write) && !mem_finished,
		we: id_exe.mem_write,
		addr: result,
		wdata: id_exe.store_data
	};

	assign load_word = mem_finished ? load_buf : rdata;

	assign exe_dest = '{
		valid: id_exe.valid && id_exe.reg_write,
		dest: id_exe.dest,
		data: result
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_finished <= 1'b0;
			wb.valid <= 1'b0;
		end else if (!hold) begin
			mem_finished <= 1'b0;
			wb.valid <= exe_dest.valid;
			wb.dest <= id_exe.dest;
			wb.data <= id_exe.mem_read ? load_word : result;
		end else if (data_done) begin
			mem_finished <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (data_done) begin
			load_buf <= rdata;
		end
	end

endmodule

`default_nettype wire

//--- decoder.sv
`default_nettype none

module decoder import zhxpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire mem_hold,
	input wire if_id_t if_id,
	output reg_addr_t rd_addr1,
	output reg_addr_t rd_addr2,
	input wire word_t rd_data1,
	input wire word_t rd_data2,
	input wire wb_t exe_dest,
	input wire wb_t wb,
	output logic hold,
	output logic set_pc,
	output word_t set_pc_addr,
	output id_exe_t id_exe
);
	inst_t inst;
	word_t next_pc;
	id_exe_t d;
	logic use1;
	logic use2;
	logic taken;
	logic hazard;

	function automatic logic pending(reg_addr_t a, wb_t e, wb_t w);
		return (e.valid && e.dest == a) || (w.valid && w.dest == a);
	endfunction

	assign inst = if_id.inst;
	assign next_pc = if_id.pc + 16'd1;
	// rx and ry sit at the same bits in every layout
	assign rd_addr1 = inst.i_fmt.rx;
	assign rd_addr2 = inst.m_fmt.ry;

	always_comb begin
		d = '0;
		d.alu_op = ALU_PASS;
		d.op1 = rd_data1;
		d.op2 = rd_data2;
		d.store_data = rd_data2;
		use1 = 1'b0;
		use2 = 1'b0;
		taken = 1'b0;
		set_pc_addr = next_pc;
		case (inst.r_fmt.opcode)
			OP_LI: begin
				d.op2 = {8'h00, inst.i_fmt.imm8};
				d.reg_write = 1'b1;
				d.dest = inst.i_fmt.rx;
			end
			OP_ADDIU: begin
				use1 = 1'b1;
				d.alu_op = ALU_ADD;
				d.op2 = {{8{inst.i_fmt.imm8[7]}}, inst.i_fmt.imm8};
				d.reg_write = 1'b1;
				d.dest = inst.i_fmt.rx;
			end
			OP_RRR: begin
				use1 = 1'b1;
				use2 = 1'b1;
				d.alu_op = (inst.r_fmt.func == FUNC_SUBU) ? ALU_SUB : ALU_ADD;
				d.reg_write = (inst.r_fmt.func == FUNC_ADDU) || (inst.r_fmt.func == FUNC_SUBU);
				d.dest = inst.r_fmt.rz;
			end
			OP_RR: begin
				use1 = 1'b1;
				use2 = 1'b1;
				d.alu_op = (inst.m_fmt.imm5 == FUNC_OR) ? ALU_OR : ALU_AND;
				d.reg_write = (inst.m_fmt.imm5 == FUNC_AND) || (inst.m_fmt.imm5 == FUNC_OR);
				d.dest = inst.m_fmt.rx;
			end
			OP_SLL: begin
				use2 = 1'b1;
				d.alu_op = ALU_SLL;
				d.op1 = rd_data2;
				// A shift field of zero means eight
				d.op2 = (inst.m_fmt.imm5[4:2] == 3'd0) ? 16'd8 : {13'd0, inst.m_fmt.imm5[4:2]};
				d.reg_write = 1'b1;
				d.dest = inst.m_fmt.rx;
			end
			OP_LW: begin
				use1 = 1'b1;
				d.alu_op = ALU_ADD;
				d.op2 = {{11{inst.m_fmt.imm5[4]}}, inst.m_fmt.imm5};
				d.mem_read = 1'b1;
				d.reg_write = 1'b1;
				d.dest = inst.m_fmt.ry;
			end
			OP_SW: begin
				use1 = 1'b1;
				use2 = 1'b1;
				d.alu_op = ALU_ADD;
				d.op2 = {{11{inst.m_fmt.imm5[4]}}, inst.m_fmt.imm5};
				d.mem_write = 1'b1;
			end
			OP_BEQZ: begin
				use1 = 1'b1;
				taken = (rd_data1 == 16'h0000);
				set_pc_addr = next_pc + {{8{inst.i_fmt.imm8[7]}}, inst.i_fmt.imm8};
			end
			OP_B: begin
				taken = 1'b1;
				set_pc_addr = next_pc + {{5{inst.i_fmt.rx[2]}}, inst.i_fmt.rx, inst.i_fmt.imm8};
			end
			OP_NOP: ;
			default: ;
		endcase
	end

	assign hazard = if_id.valid && ((use1 && pending(rd_addr1, exe_dest, wb)) ||
		(use2 && pending(rd_addr2, exe_dest, wb)));
	assign hold = mem_hold || hazard;
	assign set_pc = if_id.valid && taken;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_exe.valid <= 1'b0;
		end else if (!mem_hold) begin
			// On a hazard IF/ID stays put and a bubble goes on to EXE
			id_exe <= d;
			id_exe.valid <= if_id.valid && !hazard;
		end
	end

endmodule

`default_nettype wire

//--- pc_fetch.sv
`default_nettype none

module pc_fetch import zhxpu_pkg::*; #(
	parameter word_t RESET_PC = 16'h0000
) (
	input wire clk,
	input wire rst_n,
	input wire hold,
	input wire set_pc,
	input wire word_t set_pc_addr,
	output mem_req_t fetch_req,
	input wire fetch_done,
	input wire word_t rdata,
	output logic inst_ready,
	output if_id_t if_id
);
	word_t pc;
	logic buf_valid;
	word_t buf_word;

	// Keep asking for the word at pc until it sits in the buffer
	assign fetch_req = '{
		en: !buf_valid,
		we: 1'b0,
		addr: pc,
		wdata: 16'h0000
	};

	assign inst_ready = buf_valid || fetch_done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			buf_valid <= 1'b0;
			if_id.valid <= 1'b0;
		end else if (!hold) begin
			// Not held means a word is ready, either buffered or arriving now
			pc <= set_pc ? set_pc_addr : pc + 16'd1;
			buf_valid <= 1'b0;
			if_id.valid <= 1'b1;
			if_id.pc <= pc;
			if_id.inst <= buf_valid ? buf_word : rdata;
		end else if (fetch_done) begin
			buf_valid <= 1'b1;
		end
	end

	// Parks a fetched word while the pipeline is stalled
	always_ff @(posedge clk) begin
		if (fetch_done) begin
			buf_word <= rdata;
		end
	end

endmodule

`default_nettype wire

//--- ram_controller.sv
`default_nettype none

module ram_controller import zhxpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire mem_req_t fetch_req,
	input wire mem_req_t data_req,
	input wire inst_ready,
	output mem_req_t mem_req,
	input wire mem_done,
	input wire word_t mem_rdata,
	output word_t rdata,
	output logic fetch_done,
	output logic data_done,
	output logic mem_hold
);
	logic busy;
	logic grant_data;

	// Owner is latched and kept until done
	// Data side wins ties
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			grant_data <= 1'b0;
		end else if (busy) begin
			if (mem_done) begin
				busy <= 1'b0;
			end
		end else if (data_req.en) begin
			busy <= 1'b1;
			grant_data <= 1'b1;
		end else if (fetch_req.en) begin
			busy <= 1'b1;
			grant_data <= 1'b0;
		end
	end

	always_comb begin
		mem_req = '0;
		if (busy) begin
			mem_req = grant_data ? data_req : fetch_req;
		end
	end

	assign rdata = mem_rdata;
	assign fetch_done = busy && !grant_data && mem_done;
	assign data_done = busy && grant_data && mem_done;

	// Whole pipeline waits on EXE memory or on a missing instruction
	assign mem_hold = (data_req.en && !data_done) || !inst_ready;

endmodule

`default_nettype wire

//--- register_file.sv
`default_nettype none

module register_file import zhxpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire reg_addr_t rd_addr1,
	input wire reg_addr_t rd_addr2,
	output word_t rd_data1,
	output word_t rd_data2,
	input wire wb_t wb
);
	word_t regs [8];

	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	// Writes land at the edge and the interlock waits for them
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.dest] <= wb.data;
		end
	end

endmodule

`default_nettype wire

//--- zhxpu.f
zhxpu_pkg.sv
pc_fetch.sv
decoder.sv
register_file.sv
alu.sv
ram_controller.sv
zhxpu.sv
zhxpu_props.sv
zhxpu_tb.sv

//--- zhxpu.sv
`default_nettype none

module zhxpu import zhxpu_pkg::*; #(
	parameter word_t RESET_PC = 16'h0000
) (
	input wire clk,
	input wire rst_n,
	output mem_req_t mem_req,
	input wire mem_done,
	input wire word_t mem_rdata
);
	mem_req_t fetch_req;
	mem_req_t data_req;
	word_t rdata;
	logic fetch_done;
	logic data_done;
	logic inst_ready;
	logic mem_hold;
	logic hold;
	logic set_pc;
	word_t set_pc_addr;
	if_id_t if_id;
	id_exe_t id_exe;
	reg_addr_t rd_addr1;
	reg_addr_t rd_addr2;
	word_t rd_data1;
	word_t rd_data2;
	wb_t exe_dest;
	wb_t wb;

	// IF
	pc_fetch #(
		.RESET_PC(RESET_PC)
	) __pc_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.set_pc(set_pc),
		.set_pc_addr(set_pc_addr),
		.fetch_req(fetch_req),
		.fetch_done(fetch_done),
		.rdata(rdata),
		.inst_ready(inst_ready),
		.if_id(if_id)
	);

	// ID
	decoder __decoder (
		.clk(clk),
		.rst_n(rst_n),
		.mem_hold(mem_hold),
		.if_id(if_id),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.exe_dest(exe_dest),
		.wb(wb),
		.hold(hold),
		.set_pc(set_pc),
		.set_pc_addr(set_pc_addr),
		.id_exe(id_exe)
	);

	register_file __register_file (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2),
		.wb(wb)
	);

	// EXE with its result registered for WB
	alu __alu (
		.clk(clk),
		.rst_n(rst_n),
		.hold(mem_hold),
		.id_exe(id_exe),
		.data_req(data_req),
		.data_done(data_done),
		.rdata(rdata),
		.exe_dest(exe_dest),
		.wb(wb)
	);

	ram_controller __ram_controller (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.data_req(data_req),
		.inst_ready(inst_ready),
		.mem_req(mem_req),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.rdata(rdata),
		.fetch_done(fetch_done),
		.data_done(data_done),
		.mem_hold(mem_hold)
	);

endmodule

`default_nettype wire

//--- zhxpu_pkg.sv
`default_nettype none

package zhxpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;

	// One instruction word, read through whichever layout the opcode calls for
	typedef union packed {
		struct packed {
			logic [4:0] opcode;
			reg_addr_t rx;
			reg_addr_t ry;
			reg_addr_t rz;
			logic [1:0] func;
		} r_fmt;
		struct packed {
			logic [4:0] opcode;
			reg_addr_t rx;
			logic [7:0] imm8;
		} i_fmt;
		struct packed {
			logic [4:0] opcode;
			reg_addr_t rx;
			reg_addr_t ry;
			logic [4:0] imm5;
		} m_fmt;
	} inst_t;

	// THCO MIPS16 opcodes
	localparam logic [4:0] OP_NOP = 5'b00001;
	localparam logic [4:0] OP_B = 5'b00010;
	localparam logic [4:0] OP_BEQZ = 5'b00100;
	localparam logic [4:0] OP_SLL = 5'b00110;
	localparam logic [4:0] OP_ADDIU = 5'b01001;
	localparam logic [4:0] OP_LI = 5'b01101;
	localparam logic [4:0] OP_LW = 5'b10011;
	localparam logic [4:0] OP_SW = 5'b11011;
	localparam logic [4:0] OP_RRR = 5'b11100;
	localparam logic [4:0] OP_RR = 5'b11101;

	localparam logic [1:0] FUNC_ADDU = 2'b01;
	localparam logic [1:0] FUNC_SUBU = 2'b11;
	// AND and OR use the whole low five bits
	localparam logic [4:0] FUNC_AND = 5'b01100;
	localparam logic [4:0] FUNC_OR = 5'b01101;

	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR = 3'd3;
	localparam logic [2:0] ALU_SLL = 3'd4;
	localparam logic [2:0] ALU_PASS = 3'd5;

	typedef struct packed {
		logic en;
		logic we;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		inst_t inst;
	} if_id_t;

	typedef struct packed {
		logic valid;
		logic [2:0] alu_op;
		word_t op1;
		word_t op2;
		word_t store_data;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		reg_addr_t dest;
	} id_exe_t;

	typedef struct packed {
		logic valid;
		reg_addr_t dest;
		word_t data;
	} wb_t;

endpackage

`default_nettype wire

//--- zhxpu_props.sv
`default_nettype none

module zhxpu_props import zhxpu_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire mem_req_t mem_req,
	input wire mem_done
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0;

	// A pending request may not move until the memory answers
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.en && !mem_done |=> $stable(mem_req))
	else begin
		$error("memory request changed before mem_done");
		fail_count++;
	end

	en_after_reset: assert property (@(posedge clk) !rst_n |=> !mem_req.en)
	else begin
		$error("memory request enabled right after reset");
		fail_count++;
	end

	we_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.we |-> mem_req.en)
	else begin
		$error("write strobe without enable on the memory port");
		fail_count++;
	end

endmodule

bind ram_controller zhxpu_props u_props (
	.clk(clk),
	.rst_n(rst_n),
	.mem_req(mem_req),
	.mem_done(mem_done)
);

`default_nettype wire

//--- zhxpu_tb.sv
`default_nettype none

module zhxpu_tb import zhxpu_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam word_t RESET_PC = 16'h0010;
	localparam int MAX_INSTR = 400;
	// Fetch, data access and interlock stalls at their longest
	localparam int WORST_CPI = 16;
	localparam int TIMEOUT_NS = MAX_INSTR * WORST_CPI * 4;

	logic clk = 1'b0;
	logic rst_n;
	mem_req_t mem_req;
	logic mem_done;
	word_t mem_rdata;

	word_t mem [256];
	word_t exp_addr [MAX_INSTR];
	word_t exp_data [MAX_INSTR];
	word_t got_addr [$];
	word_t got_data [$];
	int load_ptr;
	int n_expected;
	int n_checked = 0;
	int n_req = 0;
	word_t first_addr;
	logic [31:0] rnd = 32'h1c17;

	zhxpu #(
		.RESET_PC(RESET_PC)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t i_word(input logic [4:0] op, input logic [2:0] rx,
		input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic word_t m_word(input logic [4:0] op, input logic [2:0] rx,
		input logic [2:0] ry, input logic [4:0] imm);
		return {op, rx, ry, imm};
	endfunction

	function automatic word_t r_word(input logic [2:0] rx, input logic [2:0] ry,
		input logic [2:0] rz, input logic [1:0] func);
		return {OP_RRR, rx, ry, rz, func};
	endfunction

	function automatic word_t b_word(input logic [10:0] imm);
		return {OP_B, imm};
	endfunction

	task automatic emit(input word_t w);
		mem[load_ptr] = w;
		load_ptr++;
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "check %s failed", name);
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'(i) ^ 8'ha5, 8'(i)};
		end
		load_ptr = RESET_PC;
		emit(i_word(OP_LI, 3'd7, 8'h80));
		emit(i_word(OP_LI, 3'd1, 8'h35));
		emit(i_word(OP_ADDIU, 3'd1, 8'hf0));
		emit(i_word(OP_LI, 3'd2, 8'h0c));
		emit(r_word(3'd1, 3'd2, 3'd3, FUNC_ADDU));
		emit(r_word(3'd2, 3'd1, 3'd4, FUNC_SUBU));
		emit(m_word(OP_SW, 3'd7, 3'd3, 5'd0));
		emit(m_word(OP_SW, 3'd7, 3'd4, 5'd1));
		emit(m_word(OP_RR, 3'd3, 3'd4, FUNC_AND));
		emit(m_word(OP_RR, 3'd4, 3'd2, FUNC_OR));
		emit(m_word(OP_SLL, 3'd5, 3'd3, 5'b01000));
		// Shift field of zero shifts by eight
		emit(m_word(OP_SLL, 3'd6, 3'd1, 5'b00000));
		emit(m_word(OP_SW, 3'd7, 3'd3, 5'd2));
		emit(m_word(OP_SW, 3'd7, 3'd4, 5'd3));
		emit(m_word(OP_SW, 3'd7, 3'd5, 5'd4));
		emit(m_word(OP_SW, 3'd7, 3'd6, 5'd5));
		// Store then load back the same word
		emit(i_word(OP_ADDIU, 3'd5, 8'h7f));
		emit(m_word(OP_SW, 3'd7, 3'd5, 5'd6));
		emit(m_word(OP_LW, 3'd7, 3'd1, 5'd6));
		emit(i_word(OP_ADDIU, 3'd1, 8'h01));
		emit(m_word(OP_SW, 3'd7, 3'd1, 5'd7));
		emit(m_word(OP_LW, 3'd7, 3'd2, 5'd15));
		emit(m_word(OP_SW, 3'd7, 3'd2, 5'd8));
		// Counted loop where r3 counts delay-slot runs
		emit(i_word(OP_LI, 3'd1, 8'h05));
		emit(i_word(OP_LI, 3'd3, 8'h00));
		emit(i_word(OP_ADDIU, 3'd7, 8'h10));
		emit(i_word(OP_ADDIU, 3'd1, 8'hff));
		emit(m_word(OP_SW, 3'd7, 3'd1, 5'd0));
		emit(i_word(OP_ADDIU, 3'd7, 8'h01));
		emit(i_word(OP_BEQZ, 3'd1, 8'h03));
		emit(i_word(OP_ADDIU, 3'd3, 8'h01));
		emit(b_word(11'h7fa));
		emit(i_word(OP_NOP, 3'd0, 8'h00));
		emit(m_word(OP_SW, 3'd7, 3'd3, 5'd0));
		// Branch to itself ends the program
		emit(b_word(11'h7ff));
		emit(i_word(OP_NOP, 3'd0, 8'h00));
	endtask

	// Runs the image one instruction at a time and lists its stores
	function automatic int run_reference();
		word_t m [256];
		word_t r [8];
		word_t w;
		word_t pc;
		word_t npc;
		word_t cur;
		word_t ea;
		word_t target;
		logic [2:0] x;
		logic [2:0] y;
		logic [2:0] z;
		int n;
		int steps;
		bit halt;
		m = mem;
		foreach (r[i]) begin
			r[i] = '0;
		end
		pc = RESET_PC;
		npc = RESET_PC + 16'd1;
		n = 0;
		steps = 0;
		halt = 1'b0;
		while (!halt && steps < MAX_INSTR) begin
			w = m[pc[7:0]];
			x = w[10:8];
			y = w[7:5];
			z = w[4:2];
			cur = pc;
			pc = npc;
			npc = npc + 16'd1;
			steps++;
			ea = r[x] + {{11{w[4]}}, w[4:0]};
			case (w[15:11])
				OP_LI: r[x] = {8'h00, w[7:0]};
				OP_ADDIU: r[x] = r[x] + {{8{w[7]}}, w[7:0]};
				OP_RRR: begin
					if (w[1:0] == FUNC_ADDU) r[z] = r[x] + r[y];
					if (w[1:0] == FUNC_SUBU) r[z] = r[x] - r[y];
				end
				OP_RR: begin
					if (w[4:0] == FUNC_AND) r[x] = r[x] & r[y];
					if (w[4:0] == FUNC_OR) r[x] = r[x] | r[y];
				end
				OP_SLL: r[x] = r[y] << ((z == 3'd0) ? 8 : z);
				OP_LW: r[y] = m[ea[7:0]];
				OP_SW: begin
					m[ea[7:0]] = r[y];
					exp_addr[n] = ea;
					exp_data[n] = r[y];
					n++;
				end
				// Branch targets take effect after the delay slot
				OP_BEQZ: begin
					if (r[x] == 16'h0000) npc = cur + 16'd1 + {{8{w[7]}}, w[7:0]};
				end
				OP_B: begin
					target = cur + 16'd1 + {{5{w[10]}}, w[10:0]};
					halt = (target == cur);
					npc = target;
				end
				default: ;
			endcase
		end
		return n;
	endfunction

	// Memory with 1 to 4 cycles of latency per access
	always begin : memory_model
		int lat;
		mem_req_t req;
		@(posedge clk);
		#1;
		if (rst_n && mem_req.en) begin
			if (n_req == 0) first_addr = mem_req.addr;
			n_req++;
			rnd = xorshift(rnd);
			lat = 1 + int'(rnd % 4);
			repeat (lat - 1) begin
				@(posedge clk);
				#1;
			end
			req = mem_req;
			if (req.we) begin
				mem[req.addr[7:0]] = req.wdata;
				got_addr.push_back(req.addr);
				got_data.push_back(req.wdata);
			end
			mem_rdata = mem[req.addr[7:0]];
			mem_done = 1'b1;
			@(posedge clk);
			#1;
			mem_done = 1'b0;
		end
	end

	always @(negedge clk) begin : compare_stores
		word_t a;
		word_t d;
		while (got_addr.size() > 0) begin
			a = got_addr.pop_front();
			d = got_data.pop_front();
			if (n_checked >= n_expected) begin
				$display("Unexpected store of %h to address %h after the last expected one", d, a);
				$display("TESTS FAILED");
				$fatal(1, "extra store");
			end else begin
				check_value($sformatf("store %0d address", n_checked), exp_addr[n_checked], a);
				check_value($sformatf("store %0d data", n_checked), exp_data[n_checked], d);
				n_checked++;
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, the core did not finish its program", TIMEOUT_NS);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : main
		rst_n = 1'b0;
		mem_done = 1'b0;
		mem_rdata = '0;
		load_program();
		n_expected = run_reference();
		repeat (2) @(posedge clk);
		#1;
		check_value("en_in_reset", 16'd0, {15'd0, mem_req.en});
		rst_n = 1'b1;
		wait (n_req > 0);
		check_value("first_fetch_addr", RESET_PC, first_addr);
		wait (n_checked == n_expected);
		// Let the halt loop spin to catch stray stores
		repeat (40) @(posedge clk);
		if (u_dut.__ram_controller.u_props.fail_count != 0) begin
			$display("%0d assertions on the memory port failed",
				u_dut.__ram_controller.u_props.fail_count);
			$display("TESTS FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
